// File: axil_pkg.sv
package axil_pkg;

  localparam int AXIL_ADDR_W = 16;
  localparam int AXIL_DATA_W = 32;
  localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

  // response codes as they appear on bresp and rresp
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;
  localparam logic [1:0] RESP_DECERR = 2'b11;

  // write address channel
  typedef struct packed {
    logic [AXIL_ADDR_W-1:0] addr;
  } axil_aw_t;

  // write data channel, one strobe bit per byte lane
  typedef struct packed {
    logic [AXIL_DATA_W-1:0] data;
    logic [AXIL_STRB_W-1:0] strb;
  } axil_w_t;

  // write response channel
  typedef struct packed {
    logic [1:0] resp;
  } axil_b_t;

  // read address channel
  typedef struct packed {
    logic [AXIL_ADDR_W-1:0] addr;
  } axil_ar_t;

  // read data channel
  typedef struct packed {
    logic [AXIL_DATA_W-1:0] data;
    logic [1:0]             resp;
  } axil_r_t;

endpackage

// File: regmap_pkg.sv
package regmap_pkg;

  import axil_pkg::*;

  localparam int NUM_BANKS     = 3;
  localparam int SEL_W         = 2;
  localparam int SUB_ADDR_W    = AXIL_ADDR_W - SEL_W;
  localparam int REGS_PER_BANK = 8;
  localparam int REG_IDX_W     = 3;
  localparam int REG_IDX_LSB   = 2;

  // the select field can name banks that are not there
  localparam bit NEED_RANGE_CHECK = (1 << SEL_W) > NUM_BANKS;

  // bank number taken from the top of the address
  function automatic logic [SEL_W-1:0] addr_sel(input logic [AXIL_ADDR_W-1:0] addr);
    return addr[AXIL_ADDR_W-1 -: SEL_W];
  endfunction

  // address as a bank sees it, with the select bits zeroed
  function automatic logic [AXIL_ADDR_W-1:0] addr_strip(input logic [AXIL_ADDR_W-1:0] addr);
    return {{SEL_W{1'b0}}, addr[SUB_ADDR_W-1:0]};
  endfunction

  function automatic logic [REG_IDX_W-1:0] addr_reg_idx(input logic [AXIL_ADDR_W-1:0] addr);
    return addr[REG_IDX_LSB +: REG_IDX_W];
  endfunction

  // true when the word offset inside the bank hits a real register
  function automatic logic addr_in_bank(input logic [AXIL_ADDR_W-1:0] addr);
    return addr[SUB_ADDR_W-1:REG_IDX_LSB] < REGS_PER_BANK;
  endfunction

endpackage

// File: axil_skidbuf.sv
`timescale 1ns/1ps

// two-entry skid buffer so that o_ready comes straight from a flop
// while still passing one item per cycle
module axil_skidbuf import axil_pkg::*; #(
  parameter type T = axil_b_t
) (
  input  logic clk,
  input  logic rst_n,
  input  logic i_valid,
  input  T     i_data,
  output logic o_ready,
  output logic o_valid,
  output T     o_data,
  input  logic i_ready
);

  logic skid_valid;
  T     skid_data;
  logic take_in;
  logic out_free;

  // ready drops only once the output and the skid entry both hold an item
  assign o_ready  = !skid_valid;
  assign take_in  = i_valid && o_ready;
  assign out_free = !o_valid || i_ready;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      o_valid    <= skid_valid || take_in;
      skid_valid <= 1'b0;
    end else if (take_in) begin
      skid_valid <= 1'b1;
    end
  end

  // with the skid entry full no input is taken, so the two loads never collide
  always_ff @(posedge clk) begin
    if (out_free) begin
      if (skid_valid) begin
        o_data <= skid_data;
      end else if (take_in) begin
        o_data <= i_data;
      end
    end
    if (take_in && !out_free) begin
      skid_data <= i_data;
    end
  end

  a_hold_stable : assert property (@(posedge clk) disable iff (rst_n)
    o_valid && !i_ready |=> o_valid && $stable(o_data));

endmodule

// File: axil_router_wr.sv
`timescale 1ns/1ps

// routes one write at a time from the manager port to one bank
// the next write is not taken until the manager has the response of this one
module axil_router_wr
  import axil_pkg::*;
  import regmap_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_aw_valid,
  input  axil_aw_t                   i_aw,
  output logic                       o_aw_ready,
  input  logic                       i_w_valid,
  input  axil_w_t                    i_w,
  output logic                       o_w_ready,
  output logic                       o_b_valid,
  output axil_b_t                    o_b,
  input  logic                       i_b_ready,
  output logic     [NUM_BANKS-1:0]   o_m_aw_valid,
  output axil_aw_t [NUM_BANKS-1:0]   o_m_aw,
  input  logic     [NUM_BANKS-1:0]   i_m_aw_ready,
  output logic     [NUM_BANKS-1:0]   o_m_w_valid,
  output axil_w_t  [NUM_BANKS-1:0]   o_m_w,
  input  logic     [NUM_BANKS-1:0]   i_m_w_ready,
  input  logic     [NUM_BANKS-1:0]   i_m_b_valid,
  input  axil_b_t  [NUM_BANKS-1:0]   i_m_b,
  output logic     [NUM_BANKS-1:0]   o_m_b_ready
);

  logic                      active;
  logic                      active_next;
  logic                      err;
  logic                      err_next;
  logic [SEL_W-1:0]          sel;
  logic [SEL_W-1:0]          sel_next;

  logic                      sb_aw_valid;
  axil_aw_t                  sb_aw;
  logic                      sb_aw_ready;
  logic                      sb_w_valid;
  axil_w_t                   sb_w;
  logic                      sb_w_ready;
  logic                      sb_b_valid;
  axil_b_t                   sb_b;
  logic                      sb_b_ready;

  logic     [NUM_BANKS-1:0]  sb_m_b_valid;
  axil_b_t  [NUM_BANKS-1:0]  sb_m_b;
  logic     [NUM_BANKS-1:0]  sb_m_b_ready;

  logic     [NUM_BANKS-1:0]  aw_valid_next;
  axil_aw_t [NUM_BANKS-1:0]  aw_next;
  logic     [NUM_BANKS-1:0]  w_valid_next;
  axil_w_t  [NUM_BANKS-1:0]  w_next;

  axil_skidbuf #(.T(axil_aw_t)) u_aw_sb (
    .clk(clk), .rst_n(rst_n),
    .i_valid(i_aw_valid), .i_data(i_aw), .o_ready(o_aw_ready),
    .o_valid(sb_aw_valid), .o_data(sb_aw), .i_ready(sb_aw_ready)
  );

  axil_skidbuf #(.T(axil_w_t)) u_w_sb (
    .clk(clk), .rst_n(rst_n),
    .i_valid(i_w_valid), .i_data(i_w), .o_ready(o_w_ready),
    .o_valid(sb_w_valid), .o_data(sb_w), .i_ready(sb_w_ready)
  );

  axil_skidbuf #(.T(axil_b_t)) u_b_sb (
    .clk(clk), .rst_n(rst_n),
    .i_valid(sb_b_valid), .i_data(sb_b), .o_ready(sb_b_ready),
    .o_valid(o_b_valid), .o_data(o_b), .i_ready(i_b_ready)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_m_b_sb
    axil_skidbuf #(.T(axil_b_t)) u_m_b_sb (
      .clk(clk), .rst_n(rst_n),
      .i_valid(i_m_b_valid[i]), .i_data(i_m_b[i]), .o_ready(o_m_b_ready[i]),
      .o_valid(sb_m_b_valid[i]), .o_data(sb_m_b[i]), .i_ready(sb_m_b_ready[i])
    );
  end

  always_comb begin
    active_next   = active;
    err_next      = err;
    sel_next      = sel;
    aw_valid_next = o_m_aw_valid & ~i_m_aw_ready;
    w_valid_next  = o_m_w_valid & ~i_m_w_ready;
    aw_next       = o_m_aw;
    w_next        = o_m_w;
    sb_aw_ready   = 1'b0;
    sb_w_ready    = 1'b0;

    if (!active) begin
      // address and data are taken together so the bank sees them as a pair
      if (sb_aw_valid && sb_w_valid) begin
        active_next = 1'b1;
        sel_next    = addr_sel(sb_aw.addr);
        sb_aw_ready = 1'b1;
        sb_w_ready  = 1'b1;
        if (NEED_RANGE_CHECK && sel_next >= SEL_W'(NUM_BANKS)) begin
          err_next = 1'b1;
        end else begin
          aw_valid_next[sel_next]  = 1'b1;
          aw_next[sel_next].addr   = addr_strip(sb_aw.addr);
          w_valid_next[sel_next]   = 1'b1;
          w_next[sel_next]         = sb_w;
        end
      end
    end else if (o_b_valid && i_b_ready) begin
      active_next = 1'b0;
      err_next    = 1'b0;
    end
  end

  // once the response sits in the output buffer nothing more is pushed
  always_comb begin
    sb_m_b_ready = '0;
    sb_b_valid   = 1'b0;
    sb_b         = '{resp: RESP_DECERR};
    if (active && !o_b_valid) begin
      if (err) begin
        sb_b_valid = 1'b1;
      end else begin
        sb_b_valid        = sb_m_b_valid[sel];
        sb_b              = sb_m_b[sel];
        sb_m_b_ready[sel] = sb_b_ready;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      active       <= 1'b0;
      err          <= 1'b0;
      o_m_aw_valid <= '0;
      o_m_w_valid  <= '0;
    end else begin
      active       <= active_next;
      err          <= err_next;
      o_m_aw_valid <= aw_valid_next;
      o_m_w_valid  <= w_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    sel    <= sel_next;
    o_m_aw <= aw_next;
    o_m_w  <= w_next;
  end

  a_bank_valid_active : assert property (@(posedge clk) disable iff (rst_n)
    (|o_m_aw_valid || |o_m_w_valid) |-> active);

  a_one_bank_aw : assert property (@(posedge clk) disable iff (rst_n)
    $onehot0(o_m_aw_valid));

endmodule

// File: axil_router_rd.sv
`timescale 1ns/1ps

// routes one read at a time from the manager port to one bank
// a bank number with nothing behind it reads as zero with DECERR
module axil_router_rd
  import axil_pkg::*;
  import regmap_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       i_ar_valid,
  input  axil_ar_t                   i_ar,
  output logic                       o_ar_ready,
  output logic                       o_r_valid,
  output axil_r_t                    o_r,
  input  logic                       i_r_ready,
  output logic     [NUM_BANKS-1:0]   o_m_ar_valid,
  output axil_ar_t [NUM_BANKS-1:0]   o_m_ar,
  input  logic     [NUM_BANKS-1:0]   i_m_ar_ready,
  input  logic     [NUM_BANKS-1:0]   i_m_r_valid,
  input  axil_r_t  [NUM_BANKS-1:0]   i_m_r,
  output logic     [NUM_BANKS-1:0]   o_m_r_ready
);

  logic                      active;
  logic                      active_next;
  logic                      err;
  logic                      err_next;
  logic [SEL_W-1:0]          sel;
  logic [SEL_W-1:0]          sel_next;

  logic                      sb_ar_valid;
  axil_ar_t                  sb_ar;
  logic                      sb_ar_ready;
  logic                      sb_r_valid;
  axil_r_t                   sb_r;
  logic                      sb_r_ready;

  logic     [NUM_BANKS-1:0]  sb_m_r_valid;
  axil_r_t  [NUM_BANKS-1:0]  sb_m_r;
  logic     [NUM_BANKS-1:0]  sb_m_r_ready;

  logic     [NUM_BANKS-1:0]  ar_valid_next;
  axil_ar_t [NUM_BANKS-1:0]  ar_next;

  axil_skidbuf #(.T(axil_ar_t)) u_ar_sb (
    .clk(clk), .rst_n(rst_n),
    .i_valid(i_ar_valid), .i_data(i_ar), .o_ready(o_ar_ready),
    .o_valid(sb_ar_valid), .o_data(sb_ar), .i_ready(sb_ar_ready)
  );

  axil_skidbuf #(.T(axil_r_t)) u_r_sb (
    .clk(clk), .rst_n(rst_n),
    .i_valid(sb_r_valid), .i_data(sb_r), .o_ready(sb_r_ready),
    .o_valid(o_r_valid), .o_data(o_r), .i_ready(i_r_ready)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_m_r_sb
    axil_skidbuf #(.T(axil_r_t)) u_m_r_sb (
      .clk(clk), .rst_n(rst_n),
      .i_valid(i_m_r_valid[i]), .i_data(i_m_r[i]), .o_ready(o_m_r_ready[i]),
      .o_valid(sb_m_r_valid[i]), .o_data(sb_m_r[i]), .i_ready(sb_m_r_ready[i])
    );
  end

  always_comb begin
    active_next   = active;
    err_next      = err;
    sel_next      = sel;
    ar_valid_next = o_m_ar_valid & ~i_m_ar_ready;
    ar_next       = o_m_ar;
    sb_ar_ready   = 1'b0;

    if (!active) begin
      if (sb_ar_valid) begin
        active_next = 1'b1;
        sel_next    = addr_sel(sb_ar.addr);
        sb_ar_ready = 1'b1;
        if (NEED_RANGE_CHECK && sel_next >= SEL_W'(NUM_BANKS)) begin
          err_next = 1'b1;
        end else begin
          ar_valid_next[sel_next] = 1'b1;
          ar_next[sel_next].addr  = addr_strip(sb_ar.addr);
        end
      end
    end else if (o_r_valid && i_r_ready) begin
      active_next = 1'b0;
      err_next    = 1'b0;
    end
  end

  always_comb begin
    sb_m_r_ready = '0;
    sb_r_valid   = 1'b0;
    sb_r         = '{data: '0, resp: RESP_DECERR};
    if (active && !o_r_valid) begin
      if (err) begin
        sb_r_valid = 1'b1;
      end else begin
        sb_r_valid        = sb_m_r_valid[sel];
        sb_r              = sb_m_r[sel];
        sb_m_r_ready[sel] = sb_r_ready;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      active       <= 1'b0;
      err          <= 1'b0;
      o_m_ar_valid <= '0;
    end else begin
      active       <= active_next;
      err          <= err_next;
      o_m_ar_valid <= ar_valid_next;
    end
  end

  always_ff @(posedge clk) begin
    sel    <= sel_next;
    o_m_ar <= ar_next;
  end

  a_bank_ar_active : assert property (@(posedge clk) disable iff (rst_n)
    |o_m_ar_valid |-> active);

endmodule

// File: axil_reg_bank.sv
`timescale 1ns/1ps

// a bank of byte-writable registers behind an AXI-Lite subordinate port
module axil_reg_bank
  import axil_pkg::*;
  import regmap_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     i_aw_valid,
  input  axil_aw_t i_aw,
  output logic     o_aw_ready,
  input  logic     i_w_valid,
  input  axil_w_t  i_w,
  output logic     o_w_ready,
  output logic     o_b_valid,
  output axil_b_t  o_b,
  input  logic     i_b_ready,
  input  logic     i_ar_valid,
  input  axil_ar_t i_ar,
  output logic     o_ar_ready,
  output logic     o_r_valid,
  output axil_r_t  o_r,
  input  logic     i_r_ready
);

  logic [REGS_PER_BANK-1:0][AXIL_DATA_W-1:0] regs;
  logic                                      wr_fire;
  logic                                      wr_hit;
  logic [REG_IDX_W-1:0]                      wr_idx;
  logic                                      rd_fire;
  logic                                      rd_hit;
  logic [REG_IDX_W-1:0]                      rd_idx;

  // address and data go in together, and only with no write response waiting
  assign wr_fire    = i_aw_valid && i_w_valid && !o_b_valid;
  assign o_aw_ready = wr_fire;
  assign o_w_ready  = wr_fire;
  assign wr_hit     = addr_in_bank(i_aw.addr);
  assign wr_idx     = addr_reg_idx(i_aw.addr);

  assign rd_fire    = i_ar_valid && !o_r_valid;
  assign o_ar_ready = !o_r_valid;
  assign rd_hit     = addr_in_bank(i_ar.addr);
  assign rd_idx     = addr_reg_idx(i_ar.addr);

  // an offset past the last register leaves every register unchanged
  always_ff @(posedge clk) begin
    if (rst_n) begin
      regs <= '0;
    end else if (wr_fire && wr_hit) begin
      for (int b = 0; b < AXIL_STRB_W; b++) begin
        if (i_w.strb[b]) begin
          regs[wr_idx][8*b +: 8] <= i_w.data[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      o_b_valid <= 1'b0;
      o_r_valid <= 1'b0;
    end else begin
      if (wr_fire) begin
        o_b_valid <= 1'b1;
      end else if (i_b_ready) begin
        o_b_valid <= 1'b0;
      end
      if (rd_fire) begin
        o_r_valid <= 1'b1;
      end else if (i_r_ready) begin
        o_r_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      o_b.resp <= wr_hit ? RESP_OKAY : RESP_SLVERR;
    end
    if (rd_fire) begin
      o_r.data <= rd_hit ? regs[rd_idx] : '0;
      o_r.resp <= rd_hit ? RESP_OKAY : RESP_SLVERR;
    end
  end

  a_b_held : assert property (@(posedge clk) disable iff (rst_n)
    o_b_valid && !i_b_ready |=> o_b_valid && $stable(o_b));

endmodule

// File: axil_reg_hub.sv
`timescale 1ns/1ps

// debug register hub with one manager port and NUM_BANKS register banks
module axil_reg_hub
  import axil_pkg::*;
  import regmap_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     i_aw_valid,
  input  axil_aw_t i_aw,
  output logic     o_aw_ready,
  input  logic     i_w_valid,
  input  axil_w_t  i_w,
  output logic     o_w_ready,
  output logic     o_b_valid,
  output axil_b_t  o_b,
  input  logic     i_b_ready,
  input  logic     i_ar_valid,
  input  axil_ar_t i_ar,
  output logic     o_ar_ready,
  output logic     o_r_valid,
  output axil_r_t  o_r,
  input  logic     i_r_ready
);

  logic     [NUM_BANKS-1:0] bk_aw_valid;
  logic     [NUM_BANKS-1:0] bk_aw_ready;
  axil_aw_t [NUM_BANKS-1:0] bk_aw;
  logic     [NUM_BANKS-1:0] bk_w_valid;
  logic     [NUM_BANKS-1:0] bk_w_ready;
  axil_w_t  [NUM_BANKS-1:0] bk_w;
  logic     [NUM_BANKS-1:0] bk_b_valid;
  logic     [NUM_BANKS-1:0] bk_b_ready;
  axil_b_t  [NUM_BANKS-1:0] bk_b;
  logic     [NUM_BANKS-1:0] bk_ar_valid;
  logic     [NUM_BANKS-1:0] bk_ar_ready;
  axil_ar_t [NUM_BANKS-1:0] bk_ar;
  logic     [NUM_BANKS-1:0] bk_r_valid;
  logic     [NUM_BANKS-1:0] bk_r_ready;
  axil_r_t  [NUM_BANKS-1:0] bk_r;

  axil_router_wr u_router_wr (
    .clk(clk), .rst_n(rst_n),
    .i_aw_valid(i_aw_valid), .i_aw(i_aw), .o_aw_ready(o_aw_ready),
    .i_w_valid(i_w_valid), .i_w(i_w), .o_w_ready(o_w_ready),
    .o_b_valid(o_b_valid), .o_b(o_b), .i_b_ready(i_b_ready),
    .o_m_aw_valid(bk_aw_valid), .o_m_aw(bk_aw), .i_m_aw_ready(bk_aw_ready),
    .o_m_w_valid(bk_w_valid), .o_m_w(bk_w), .i_m_w_ready(bk_w_ready),
    .i_m_b_valid(bk_b_valid), .i_m_b(bk_b), .o_m_b_ready(bk_b_ready)
  );

  axil_router_rd u_router_rd (
    .clk(clk), .rst_n(rst_n),
    .i_ar_valid(i_ar_valid), .i_ar(i_ar), .o_ar_ready(o_ar_ready),
    .o_r_valid(o_r_valid), .o_r(o_r), .i_r_ready(i_r_ready),
    .o_m_ar_valid(bk_ar_valid), .o_m_ar(bk_ar), .i_m_ar_ready(bk_ar_ready),
    .i_m_r_valid(bk_r_valid), .i_m_r(bk_r), .o_m_r_ready(bk_r_ready)
  );

  for (genvar i = 0; i < NUM_BANKS; i++) begin : gen_bank
    axil_reg_bank u_bank (
      .clk(clk), .rst_n(rst_n),
      .i_aw_valid(bk_aw_valid[i]), .i_aw(bk_aw[i]), .o_aw_ready(bk_aw_ready[i]),
      .i_w_valid(bk_w_valid[i]), .i_w(bk_w[i]), .o_w_ready(bk_w_ready[i]),
      .o_b_valid(bk_b_valid[i]), .o_b(bk_b[i]), .i_b_ready(bk_b_ready[i]),
      .i_ar_valid(bk_ar_valid[i]), .i_ar(bk_ar[i]), .o_ar_ready(bk_ar_ready[i]),
      .o_r_valid(bk_r_valid[i]), .o_r(bk_r[i]), .i_r_ready(bk_r_ready[i])
    );
  end

endmodule

// File: axil_reg_hub_tb.sv
`timescale 1ns/1ps

module axil_reg_hub_tb
  import axil_pkg::*;
  import regmap_pkg::*;
();

  localparam int TIMEOUT = 200;

  logic     clk;
  logic     rst_n;
  logic     aw_valid;
  axil_aw_t aw;
  logic     aw_ready;
  logic     w_valid;
  axil_w_t  w;
  logic     w_ready;
  logic     b_valid;
  axil_b_t  b;
  logic     b_ready;
  logic     ar_valid;
  axil_ar_t ar;
  logic     ar_ready;
  logic     r_valid;
  axil_r_t  r;
  logic     r_ready;

  integer seed = 32'h791d;
  int mismatch_cnt = 0;
  int fault_cnt = 0;

  // expected responses in issue order, popped once the handshake is past
  logic [1:0]        exp_b_q[$];
  axil_r_t           exp_r_q[$];
  logic [AXIL_DATA_W-1:0] model[NUM_BANKS][REGS_PER_BANK];

  axil_reg_hub dut0 (
    .clk(clk), .rst_n(rst_n),
    .i_aw_valid(aw_valid), .i_aw(aw), .o_aw_ready(aw_ready),
    .i_w_valid(w_valid), .i_w(w), .o_w_ready(w_ready),
    .o_b_valid(b_valid), .o_b(b), .i_b_ready(b_ready),
    .i_ar_valid(ar_valid), .i_ar(ar), .o_ar_ready(ar_ready),
    .o_r_valid(r_valid), .o_r(r), .i_r_ready(r_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  a_b_idle : assert property (@(posedge clk) $fell(rst_n) |-> !b_valid)
    else begin
      mismatch_cnt++;
      $display("MISMATCH t=%0t o_b_valid expected 0 got %b", $time, $sampled(b_valid));
    end

  a_r_idle : assert property (@(posedge clk) $fell(rst_n) |-> !r_valid)
    else begin
      mismatch_cnt++;
      $display("MISMATCH t=%0t o_r_valid expected 0 got %b", $time, $sampled(r_valid));
    end

  a_b_expected : assert property (@(posedge clk) disable iff (rst_n)
    b_valid |-> exp_b_q.size() != 0)
    else begin
      fault_cnt++;
      $display("t=%0t a write response was valid with none outstanding", $time);
    end

  a_b_resp : assert property (@(posedge clk) disable iff (rst_n)
    b_valid && b_ready && exp_b_q.size() != 0 |-> b.resp == exp_b_q[0])
    else begin
      mismatch_cnt++;
      $display("MISMATCH t=%0t o_b.resp expected %0d got %0d", $time, exp_b_q[0],
               $sampled(b.resp));
    end

  a_r_expected : assert property (@(posedge clk) disable iff (rst_n)
    r_valid |-> exp_r_q.size() != 0)
    else begin
      fault_cnt++;
      $display("t=%0t a read response was valid with none outstanding", $time);
    end

  a_r_data : assert property (@(posedge clk) disable iff (rst_n)
    r_valid && r_ready && exp_r_q.size() != 0 |-> r.data == exp_r_q[0].data)
    else begin
      mismatch_cnt++;
      $display("MISMATCH t=%0t o_r.data expected %h got %h", $time, exp_r_q[0].data,
               $sampled(r.data));
    end

  a_r_resp : assert property (@(posedge clk) disable iff (rst_n)
    r_valid && r_ready && exp_r_q.size() != 0 |-> r.resp == exp_r_q[0].resp)
    else begin
      mismatch_cnt++;
      $display("MISMATCH t=%0t o_r.resp expected %0d got %0d", $time, exp_r_q[0].resp,
               $sampled(r.resp));
    end

  function automatic logic [AXIL_ADDR_W-1:0] make_addr(input int bank, input int word);
    return {SEL_W'(bank), (SUB_ADDR_W-2)'(word), 2'b00};
  endfunction

  // each request task starts and ends on a falling edge
  task automatic send_aw(input logic [AXIL_ADDR_W-1:0] addr, input int gap);
    int waited;
    waited = 0;
    repeat (gap) @(negedge clk);
    aw_valid = 1'b1;
    aw.addr  = addr;
    while (!aw_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!aw_ready) begin
      fault_cnt++;
      $display("t=%0t timed out waiting for the write address to be accepted", $time);
    end
    @(negedge clk);
    aw_valid = 1'b0;
  endtask

  task automatic send_w(input logic [AXIL_DATA_W-1:0] data, input logic [3:0] strb,
                        input int gap);
    int waited;
    waited = 0;
    repeat (gap) @(negedge clk);
    w_valid = 1'b1;
    w.data  = data;
    w.strb  = strb;
    while (!w_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!w_ready) begin
      fault_cnt++;
      $display("t=%0t timed out waiting for the write data to be accepted", $time);
    end
    @(negedge clk);
    w_valid = 1'b0;
  endtask

  // bready stalls at random, about one cycle in four
  task automatic take_b();
    int waited;
    waited  = 0;
    b_ready = ($random(seed) & 3) != 0;
    while (!(b_valid && b_ready) && waited < TIMEOUT) begin
      @(negedge clk);
      b_ready = ($random(seed) & 3) != 0;
      waited++;
    end
    if (!(b_valid && b_ready)) begin
      fault_cnt++;
      $display("t=%0t timed out waiting for the write response", $time);
    end
    @(negedge clk);
    b_ready = 1'b0;
    if (exp_b_q.size() != 0) begin
      void'(exp_b_q.pop_front());
    end
  endtask

  task automatic write_reg(input logic [AXIL_ADDR_W-1:0] addr,
                           input logic [AXIL_DATA_W-1:0] data, input logic [3:0] strb);
    int bank;
    int word;
    int aw_gap;
    int w_gap;
    bank   = int'(addr[AXIL_ADDR_W-1 -: SEL_W]);
    word   = int'(addr[SUB_ADDR_W-1:2]);
    aw_gap = $random(seed) & 3;
    w_gap  = $random(seed) & 3;
    if (bank >= NUM_BANKS) begin
      exp_b_q.push_back(RESP_DECERR);
    end else if (word >= REGS_PER_BANK) begin
      exp_b_q.push_back(RESP_SLVERR);
    end else begin
      for (int i = 0; i < AXIL_STRB_W; i++) begin
        if (strb[i]) begin
          model[bank][word][8*i +: 8] = data[8*i +: 8];
        end
      end
      exp_b_q.push_back(RESP_OKAY);
    end
    fork
      send_aw(addr, aw_gap);
      send_w(data, strb, w_gap);
    join
    take_b();
  endtask

  task automatic read_reg(input logic [AXIL_ADDR_W-1:0] addr);
    int bank;
    int word;
    int waited;
    axil_r_t exp;
    bank   = int'(addr[AXIL_ADDR_W-1 -: SEL_W]);
    word   = int'(addr[SUB_ADDR_W-1:2]);
    waited = 0;
    exp    = '{data: '0, resp: RESP_OKAY};
    if (bank >= NUM_BANKS) begin
      exp.resp = RESP_DECERR;
    end else if (word >= REGS_PER_BANK) begin
      exp.resp = RESP_SLVERR;
    end else begin
      exp.data = model[bank][word];
    end
    exp_r_q.push_back(exp);
    ar_valid = 1'b1;
    ar.addr  = addr;
    while (!ar_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!ar_ready) begin
      fault_cnt++;
      $display("t=%0t timed out waiting for the read address to be accepted", $time);
    end
    @(negedge clk);
    ar_valid = 1'b0;
    waited   = 0;
    r_ready  = ($random(seed) & 3) != 0;
    while (!(r_valid && r_ready) && waited < TIMEOUT) begin
      @(negedge clk);
      r_ready = ($random(seed) & 3) != 0;
      waited++;
    end
    if (!(r_valid && r_ready)) begin
      fault_cnt++;
      $display("t=%0t timed out waiting for the read response", $time);
    end
    @(negedge clk);
    r_ready = 1'b0;
    if (exp_r_q.size() != 0) begin
      void'(exp_r_q.pop_front());
    end
  endtask

  task automatic read_all();
    for (int bk = 0; bk < NUM_BANKS; bk++) begin
      for (int ix = 0; ix < REGS_PER_BANK; ix++) begin
        read_reg(make_addr(bk, ix));
      end
    end
  endtask

  initial begin
    logic [AXIL_DATA_W-1:0] rnd;
    logic [AXIL_ADDR_W-1:0] addr;
    int bank;
    int word;
    rst_n    = 1'b1;
    aw_valid = 1'b0;
    aw       = '0;
    w_valid  = 1'b0;
    w        = '0;
    b_ready  = 1'b0;
    ar_valid = 1'b0;
    ar       = '0;
    r_ready  = 1'b0;
    for (int bk = 0; bk < NUM_BANKS; bk++) begin
      for (int ix = 0; ix < REGS_PER_BANK; ix++) begin
        model[bk][ix] = '0;
      end
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b0;

    read_all();

    // every word carries its own address, so a cross-bank leak shows on readback
    for (int bk = 0; bk < NUM_BANKS; bk++) begin
      for (int ix = 0; ix < REGS_PER_BANK; ix++) begin
        write_reg(make_addr(bk, ix), {make_addr(bk, ix), ~make_addr(bk, ix)}, 4'hf);
      end
    end
    read_all();

    for (int bk = 0; bk < NUM_BANKS; bk++) begin
      for (int ix = 0; ix < REGS_PER_BANK; ix++) begin
        write_reg(make_addr(bk, ix), 32'hcafe_f00d ^ AXIL_DATA_W'(ix), 4'b0101);
        write_reg(make_addr(bk, ix), 32'h1234_5678, 4'b1000);
        read_reg(make_addr(bk, ix));
      end
    end

    // bank 3 is not populated
    write_reg(make_addr(3, 1), 32'hdead_beef, 4'hf);
    read_reg(make_addr(3, 1));
    write_reg(make_addr(1, 8), 32'hbad0_0001, 4'hf);
    write_reg(make_addr(2, 100), 32'hbad0_0002, 4'hf);
    read_reg(make_addr(1, 8));
    read_reg(make_addr(0, 4095));
    read_all();

    repeat (200) begin
      bank = $random(seed) & 3;
      word = ($random(seed) & 32'h7fff) % 10;
      addr = make_addr(bank, word);
      rnd  = $random(seed);
      if (rnd[31]) begin
        write_reg(addr, $random(seed), rnd[3:0]);
      end else begin
        read_reg(addr);
      end
    end
    read_all();

    $display("errors: %0d mismatch, %0d other", mismatch_cnt, fault_cnt);
    if (mismatch_cnt == 0 && fault_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: axil_reg_hub.f
axil_pkg.sv
regmap_pkg.sv
axil_skidbuf.sv
axil_router_wr.sv
axil_router_rd.sv
axil_reg_bank.sv
axil_reg_hub.sv
axil_reg_hub_tb.sv
